// File: rtl/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // Element and bus widths
    localparam int DATA_W = 16;
    localparam int WORD_W = 32;
    localparam int ACC_W  = 36;

    // Word 0 of a command holds the opcode and word 1 the write-back address
    localparam int CMD_WORDS = 2;

    // Elements in a 3x3 window
    localparam int WIN = 9;

    // Image burst lengths in words
    localparam int DATA_BURST   = 5;
    localparam int DATA_BURST_P = 6;

    // Weight/bias burst lengths in words
    localparam int WB_BURST   = 6;
    localparam int WB_BURST_P = 8;

    localparam int CMD_DEPTH = 16;

    typedef enum logic [7:0] {
        op_idle        = 8'd0,
        op_conv3       = 8'd1,
        op_conv3_conv1 = 8'd2,
        op_pool3       = 8'd3
    } op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_collect,
        st_issue,
        st_wait,
        st_finish
    } csb_state_e;

endpackage

`default_nettype wire

// File: rtl/cmd_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module cmd_fifo import cnn_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [WORD_W-1:0] wdata,
    input  logic              rd_en,
    output logic [WORD_W-1:0] rdata,
    output logic              full,
    output logic              empty
);

    logic [WORD_W-1:0]            mem [CMD_DEPTH];
    logic [$clog2(CMD_DEPTH)-1:0] wr_ptr;
    logic [$clog2(CMD_DEPTH)-1:0] rd_ptr;
    logic [$clog2(CMD_DEPTH):0]   count;
    logic                         do_wr;
    logic                         do_rd;

    assign full  = (count == CMD_DEPTH);
    assign empty = (count == 0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head word always shows on rdata
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd) count <= count + 1'b1;
            else if (do_rd && !do_wr) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wdata;
    end

endmodule

`default_nettype wire

// File: rtl/csb.sv
`default_nettype none
`timescale 1ns/1ns

module csb import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_en,
    input  logic [WORD_W-1:0]     cmd_rdata,
    input  logic                  cmd_empty,
    output logic                  cmd_rd_en,
    input  logic [WORD_W-1:0]     data,
    input  logic                  im_empty,
    output logic                  im_rd_en,
    input  logic [WORD_W-1:0]     weightbias,
    input  logic                  iwb_empty,
    output logic                  iwb_rd_en,
    output logic                  conv_req,
    output logic                  use_1x1,
    input  logic                  conv_ack,
    input  logic [DATA_W-1:0]     conv_res_3x3,
    input  logic [DATA_W-1:0]     conv_res_1x1,
    output logic                  pool_req,
    input  logic                  pool_ack,
    input  logic [DATA_W-1:0]     pool_res,
    output logic [WIN*DATA_W-1:0] im_win,
    output logic [WIN*DATA_W-1:0] iw_win,
    output logic [DATA_W-1:0]     ib_3x3,
    output logic [DATA_W-1:0]     im_1x1,
    output logic [DATA_W-1:0]     iw_1x1,
    output logic [DATA_W-1:0]     ib_1x1,
    output logic                  wr_en,
    output logic [WORD_W-1:0]     wr_addr,
    output logic [DATA_W-1:0]     wr_data,
    output logic                  irq
);

    csb_state_e                     state;
    csb_state_e                     after_cmd;
    op_e                            opcode;
    logic [$clog2(CMD_WORDS)-1:0]   cmd_cnt;
    logic [WORD_W-1:0]              base_addr;
    logic [3:0]                     im_cnt;
    logic [3:0]                     wb_cnt;
    logic [3:0]                     im_tail;
    logic [3:0]                     wb_tail;
    logic                           wr_second;
    logic                           conv_done;
    logic                           pool_done;

    assign use_1x1 = (opcode == op_conv3_conv1);

    // Burst position where the packed window ends
    assign im_tail = use_1x1 ? 4'd2 : 4'd1;
    assign wb_tail = use_1x1 ? 4'd3 : 4'd1;

    assign cmd_rd_en = (state == st_collect) && !cmd_empty;
    assign im_rd_en  = (state == st_issue) && (im_cnt != 0) && !im_empty;
    assign iwb_rd_en = (state == st_issue) && (wb_cnt != 0) && !iwb_empty;
    assign irq       = (state == st_finish);

    assign conv_done = (state == st_wait) && !wr_second && conv_req && conv_ack;
    assign pool_done = (state == st_wait) && !wr_second && pool_req && pool_ack;
    assign after_cmd = cmd_empty ? st_finish : st_collect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            opcode    <= op_idle;
            cmd_cnt   <= '0;
            im_cnt    <= '0;
            wb_cnt    <= '0;
            conv_req  <= 1'b0;
            pool_req  <= 1'b0;
            wr_second <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                st_idle: begin
                    if (op_en) state <= st_collect;
                end
                st_collect: begin
                    if (!cmd_empty) begin
                        if (cmd_cnt == 0) opcode <= op_e'(cmd_rdata[7:0]);
                        if (cmd_cnt == CMD_WORDS - 1) begin
                            cmd_cnt <= '0;
                            state   <= st_issue;
                            case (opcode)
                                op_conv3: begin
                                    im_cnt <= 4'(DATA_BURST);
                                    wb_cnt <= 4'(WB_BURST);
                                end
                                op_conv3_conv1: begin
                                    im_cnt <= 4'(DATA_BURST_P);
                                    wb_cnt <= 4'(WB_BURST_P);
                                end
                                op_pool3: begin
                                    im_cnt <= 4'(DATA_BURST);
                                    wb_cnt <= '0;
                                end
                                // Nothing to load or compute for an unknown opcode
                                default: state <= st_wait;
                            endcase
                        end else begin
                            cmd_cnt <= cmd_cnt + 1'b1;
                        end
                    end else if (cmd_cnt == 0) begin
                        state <= st_finish;
                    end
                end
                st_issue: begin
                    if (im_rd_en) im_cnt <= im_cnt - 1'b1;
                    if (iwb_rd_en) wb_cnt <= wb_cnt - 1'b1;
                    // Both bursts in and the target unit has released ack
                    if (im_cnt == 0 && wb_cnt == 0 && !conv_ack && !pool_ack) begin
                        state <= st_wait;
                        if (opcode == op_pool3) pool_req <= 1'b1;
                        else conv_req <= 1'b1;
                    end
                end
                st_wait: begin
                    if (wr_second) begin
                        wr_second <= 1'b0;
                        wr_en     <= 1'b1;
                        state     <= after_cmd;
                    end else if (conv_done) begin
                        conv_req <= 1'b0;
                        wr_en    <= 1'b1;
                        if (use_1x1) wr_second <= 1'b1;
                        else state <= after_cmd;
                    end else if (pool_done) begin
                        pool_req <= 1'b0;
                        wr_en    <= 1'b1;
                        state    <= after_cmd;
                    end else if (!conv_req && !pool_req) begin
                        state <= after_cmd;
                    end
                end
                st_finish: begin
                    if (!op_en) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Operand windows, address and write data
    always_ff @(posedge clk) begin
        if (cmd_rd_en && cmd_cnt == CMD_WORDS - 1) base_addr <= cmd_rdata;

        if (im_rd_en) begin
            if (im_cnt > im_tail) im_win <= {im_win[WIN*DATA_W-WORD_W-1:0], data};
            else if (im_cnt == im_tail) im_win <= {im_win[WIN*DATA_W-DATA_W-1:0],
                                                   data[DATA_W-1:0]};
            else im_1x1 <= data[DATA_W-1:0];
        end

        if (iwb_rd_en) begin
            if (wb_cnt > wb_tail + 4'd1) begin
                iw_win <= {iw_win[WIN*DATA_W-WORD_W-1:0], weightbias};
            end else if (wb_cnt == wb_tail + 4'd1) begin
                iw_win <= {iw_win[WIN*DATA_W-DATA_W-1:0], weightbias[DATA_W-1:0]};
            end else if (use_1x1 && wb_cnt == 4'd3) begin
                iw_1x1 <= weightbias[DATA_W-1:0];
            end else if (use_1x1 && wb_cnt == 4'd1) begin
                ib_1x1 <= weightbias[DATA_W-1:0];
            end else begin
                ib_3x3 <= weightbias[DATA_W-1:0];
            end
        end

        if (wr_second) begin
            wr_addr <= base_addr + WORD_W'(1);
            wr_data <= conv_res_1x1;
        end else if (conv_done) begin
            wr_addr <= base_addr;
            wr_data <= conv_res_3x3;
        end else if (pool_done) begin
            wr_addr <= base_addr;
            wr_data <= pool_res;
        end
    end

endmodule

`default_nettype wire

// File: rtl/conv_unit.sv
`default_nettype none
`timescale 1ns/1ns

module conv_unit import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  use_1x1,
    input  logic [WIN*DATA_W-1:0] im_win,
    input  logic [WIN*DATA_W-1:0] iw_win,
    input  logic [DATA_W-1:0]     ib_3x3,
    input  logic [DATA_W-1:0]     im_1x1,
    input  logic [DATA_W-1:0]     iw_1x1,
    input  logic [DATA_W-1:0]     ib_1x1,
    output logic                  ack,
    output logic [DATA_W-1:0]     res_3x3,
    output logic [DATA_W-1:0]     res_1x1
);

    logic                     start;
    logic                     busy;
    logic                     use_1x1_q;
    logic [3:0]               tap;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  prod;
    logic signed [ACC_W-1:0]  sum_3x3;
    logic signed [ACC_W-1:0]  sum_1x1;

    function automatic logic [DATA_W-1:0] relu_sat(input logic signed [ACC_W-1:0] v);
        if (v < 0) return '0;
        else if (v > ACC_W'({1'b0, {(DATA_W-1){1'b1}}})) return {1'b0, {(DATA_W-1){1'b1}}};
        else return v[DATA_W-1:0];
    endfunction

    assign start = req && !busy && !ack;

    // Element 0 sits in the top slice of each window
    assign prod = $signed(im_win[(WIN-1-tap)*DATA_W +: DATA_W])
                * $signed(iw_win[(WIN-1-tap)*DATA_W +: DATA_W]);

    assign sum_3x3 = acc + $signed(ib_3x3);
    assign sum_1x1 = $signed(im_1x1) * $signed(iw_1x1) + $signed(ib_1x1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            tap       <= '0;
            ack       <= 1'b0;
            use_1x1_q <= 1'b0;
        end else begin
            if (ack && !req) ack <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                tap       <= 4'd1;
                use_1x1_q <= use_1x1;
            end else if (busy) begin
                // Extra step after the last tap for bias and ReLU
                if (tap == WIN) begin
                    busy <= 1'b0;
                    tap  <= '0;
                    ack  <= 1'b1;
                end else begin
                    tap <= tap + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) acc <= prod;
        else if (busy && tap != WIN) acc <= acc + prod;

        if (busy && tap == WIN) begin
            res_3x3 <= relu_sat(sum_3x3);
            res_1x1 <= use_1x1_q ? relu_sat(sum_1x1) : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pool_max_3x3.sv
`default_nettype none
`timescale 1ns/1ns

module pool_max_3x3 import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic [WIN*DATA_W-1:0] im_win,
    output logic                  ack,
    output logic [DATA_W-1:0]     res
);

    logic signed [DATA_W-1:0] max_val;

    // Signed maximum over the nine window elements
    always_comb begin
        max_val = $signed(im_win[0 +: DATA_W]);
        for (int i = 1; i < WIN; i++) begin
            if ($signed(im_win[i*DATA_W +: DATA_W]) > max_val)
                max_val = $signed(im_win[i*DATA_W +: DATA_W]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (req && !ack) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !ack) res <= max_val;
    end

endmodule

`default_nettype wire

// File: rtl/cnn_accel_top.sv
`default_nettype none
`timescale 1ns/1ns

module cnn_accel_top import cnn_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_en,
    input  logic              cmd_wr_en,
    input  logic [WORD_W-1:0] cmd_wdata,
    output logic              cmd_full,
    input  logic [WORD_W-1:0] data,
    input  logic              im_empty,
    output logic              im_rd_en,
    input  logic [WORD_W-1:0] weightbias,
    input  logic              iwb_empty,
    output logic              iwb_rd_en,
    output logic              wr_en,
    output logic [WORD_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              irq
);

    logic [WORD_W-1:0]     cmd_rdata;
    logic                  cmd_empty;
    logic                  cmd_rd_en;
    logic                  conv_req;
    logic                  conv_ack;
    logic                  use_1x1;
    logic [DATA_W-1:0]     conv_res_3x3;
    logic [DATA_W-1:0]     conv_res_1x1;
    logic                  pool_req;
    logic                  pool_ack;
    logic [DATA_W-1:0]     pool_res;
    logic [WIN*DATA_W-1:0] im_win;
    logic [WIN*DATA_W-1:0] iw_win;
    logic [DATA_W-1:0]     ib_3x3;
    logic [DATA_W-1:0]     im_1x1;
    logic [DATA_W-1:0]     iw_1x1;
    logic [DATA_W-1:0]     ib_1x1;

    cmd_fifo u_cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (cmd_wr_en),
        .wdata (cmd_wdata),
        .rd_en (cmd_rd_en),
        .rdata (cmd_rdata),
        .full  (cmd_full),
        .empty (cmd_empty)
    );

    csb u_csb (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_en        (op_en),
        .cmd_rdata    (cmd_rdata),
        .cmd_empty    (cmd_empty),
        .cmd_rd_en    (cmd_rd_en),
        .data         (data),
        .im_empty     (im_empty),
        .im_rd_en     (im_rd_en),
        .weightbias   (weightbias),
        .iwb_empty    (iwb_empty),
        .iwb_rd_en    (iwb_rd_en),
        .conv_req     (conv_req),
        .use_1x1      (use_1x1),
        .conv_ack     (conv_ack),
        .conv_res_3x3 (conv_res_3x3),
        .conv_res_1x1 (conv_res_1x1),
        .pool_req     (pool_req),
        .pool_ack     (pool_ack),
        .pool_res     (pool_res),
        .im_win       (im_win),
        .iw_win       (iw_win),
        .ib_3x3       (ib_3x3),
        .im_1x1       (im_1x1),
        .iw_1x1       (iw_1x1),
        .ib_1x1       (ib_1x1),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .irq          (irq)
    );

    conv_unit u_conv (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (conv_req),
        .use_1x1 (use_1x1),
        .im_win  (im_win),
        .iw_win  (iw_win),
        .ib_3x3  (ib_3x3),
        .im_1x1  (im_1x1),
        .iw_1x1  (iw_1x1),
        .ib_1x1  (ib_1x1),
        .ack     (conv_ack),
        .res_3x3 (conv_res_3x3),
        .res_1x1 (conv_res_1x1)
    );

    pool_max_3x3 u_pool (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (pool_req),
        .im_win (im_win),
        .ack    (pool_ack),
        .res    (pool_res)
    );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first five cycles
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/cnn_accel_tb.sv
`default_nettype none
`timescale 1ns/1ns

module cnn_accel_tb import cnn_pkg::*; ();

    // Rough cycle count of all six tests together
    localparam int TOTAL_LEN = 40 + 45 + 60 + 70 + 60 + 120;

    logic              clk;
    logic              rst_n;
    logic              op_en;
    logic              cmd_wr_en;
    logic [WORD_W-1:0] cmd_wdata;
    logic              cmd_full;
    logic [WORD_W-1:0] data;
    logic              im_empty;
    logic              im_rd_en;
    logic [WORD_W-1:0] weightbias;
    logic              iwb_empty;
    logic              iwb_rd_en;
    logic              wr_en;
    logic [WORD_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              irq;

    // Stream contents, pending command words, expected and observed writes
    logic [WORD_W-1:0] im_q[$];
    logic [WORD_W-1:0] wb_q[$];
    logic [WORD_W-1:0] cmd_q[$];
    logic [WORD_W-1:0] exp_addr_q[$];
    logic [DATA_W-1:0] exp_data_q[$];
    logic [WORD_W-1:0] got_addr_q[$];
    logic [DATA_W-1:0] got_data_q[$];
    logic              got_irq_q[$];
    int                got_cycle_q[$];

    logic                     im_hold = 1'b0;
    int                       im_pops = 0;
    int                       cycle = 0;
    logic [31:0]              rng_state;
    logic signed [DATA_W-1:0] cur_im [WIN];
    logic signed [DATA_W-1:0] cur_w [WIN];
    logic signed [DATA_W-1:0] cur_b3;
    logic signed [DATA_W-1:0] cur_px;
    logic signed [DATA_W-1:0] cur_w1;
    logic signed [DATA_W-1:0] cur_b1;
    int                       fail_count = 0;
    int                       test_fail = 0;
    int                       check_count = 0;
    int                       test_count = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cnn_accel_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_en      (op_en),
        .cmd_wr_en  (cmd_wr_en),
        .cmd_wdata  (cmd_wdata),
        .cmd_full   (cmd_full),
        .data       (data),
        .im_empty   (im_empty),
        .im_rd_en   (im_rd_en),
        .weightbias (weightbias),
        .iwb_empty  (iwb_empty),
        .iwb_rd_en  (iwb_rd_en),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .irq        (irq)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Signed value in -100..100
    function automatic logic signed [DATA_W-1:0] small_val();
        return DATA_W'(int'(next_rand() % 201) - 100);
    endfunction

    // Junk for halfwords the DUT must ignore
    function automatic logic [DATA_W-1:0] filler();
        return DATA_W'(next_rand());
    endfunction

    function automatic logic [DATA_W-1:0] clamp_relu(input longint v);
        if (v < 0) return '0;
        if (v > 32767) return 16'h7fff;
        return DATA_W'(v);
    endfunction

    function automatic logic [DATA_W-1:0] expect_conv3();
        longint sum;
        int     i;
        sum = cur_b3;
        for (i = 0; i < WIN; i++) sum += longint'(cur_im[i]) * longint'(cur_w[i]);
        return clamp_relu(sum);
    endfunction

    function automatic logic [DATA_W-1:0] expect_conv1();
        return clamp_relu(longint'(cur_px) * longint'(cur_w1) + longint'(cur_b1));
    endfunction

    function automatic logic [DATA_W-1:0] expect_pool();
        logic signed [DATA_W-1:0] m;
        int                       i;
        m = cur_im[0];
        for (i = 1; i < WIN; i++) begin
            if (cur_im[i] > m) m = cur_im[i];
        end
        return m;
    endfunction

    task automatic note_fail();
        fail_count++;
        test_fail++;
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: result expected %0d got %0d", name,
                     $signed(expected), $signed(actual));
            note_fail();
        end
    endtask

    task automatic check_addr(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: address expected %h got %h", name, expected, actual);
            note_fail();
        end
    endtask

    task automatic check_irq(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: irq expected %b got %b", name, expected, actual);
            note_fail();
        end
    endtask

    task automatic check_full(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: cmd_full expected %b got %b", name, expected, actual);
            note_fail();
        end
    endtask

    // Show-ahead FIFO models for the image and weight/bias streams
    always @(posedge clk) begin
        if (im_rd_en === 1'b1) begin
            if (im_empty || im_q.size() == 0) begin
                $display("im_rd_en asserted while the image FIFO was empty");
                note_fail();
            end else begin
                void'(im_q.pop_front());
                im_pops++;
            end
        end
        if (iwb_rd_en === 1'b1) begin
            if (iwb_empty || wb_q.size() == 0) begin
                $display("iwb_rd_en asserted while the weight/bias FIFO was empty");
                note_fail();
            end else begin
                void'(wb_q.pop_front());
            end
        end
        data       <= (im_q.size() > 0) ? im_q[0] : '0;
        im_empty   <= im_hold || (im_q.size() == 0);
        weightbias <= (wb_q.size() > 0) ? wb_q[0] : '0;
        iwb_empty  <= (wb_q.size() == 0);
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Result write monitor
    always @(negedge clk) begin
        if (wr_en === 1'b1) begin
            got_addr_q.push_back(wr_addr);
            got_data_q.push_back(wr_data);
            got_irq_q.push_back(irq);
            got_cycle_q.push_back(cycle);
        end
    end

    task automatic fill_random();
        int i;
        for (i = 0; i < WIN; i++) begin
            cur_im[i] = small_val();
            cur_w[i]  = small_val();
        end
        cur_b3 = small_val();
        cur_px = small_val();
        cur_w1 = small_val();
        cur_b1 = small_val();
    endtask

    // Pack operands into stream words and queue the command and its results
    task automatic stage_job(input op_e op, input logic [WORD_W-1:0] addr);
        int i;
        @(negedge clk);
        for (i = 0; i < 4; i++) im_q.push_back({cur_im[2*i], cur_im[2*i+1]});
        im_q.push_back({filler(), cur_im[8]});
        if (op == op_conv3_conv1) im_q.push_back({filler(), cur_px});
        if (op != op_pool3) begin
            for (i = 0; i < 4; i++) wb_q.push_back({cur_w[2*i], cur_w[2*i+1]});
            wb_q.push_back({filler(), cur_w[8]});
            if (op == op_conv3_conv1) wb_q.push_back({filler(), cur_w1});
            wb_q.push_back({filler(), cur_b3});
            if (op == op_conv3_conv1) wb_q.push_back({filler(), cur_b1});
        end
        cmd_q.push_back(WORD_W'(op));
        cmd_q.push_back(addr);
        exp_addr_q.push_back(addr);
        if (op == op_pool3) begin
            exp_data_q.push_back(expect_pool());
        end else begin
            exp_data_q.push_back(expect_conv3());
        end
        if (op == op_conv3_conv1) begin
            exp_addr_q.push_back(addr + 1);
            exp_data_q.push_back(expect_conv1());
        end
    endtask

    // Commands with an opcode outside op_e load nothing and write nothing
    task automatic stage_unknown(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            cmd_q.push_back(32'h0000_00ff);
            cmd_q.push_back(32'h0000_0700);
        end
    endtask

    task automatic send_commands(input string name);
        int sent;
        sent = 0;
        while (cmd_q.size() > 0) begin
            @(posedge clk);
            cmd_wr_en <= 1'b1;
            cmd_wdata <= cmd_q.pop_front();
            sent++;
        end
        @(posedge clk);
        cmd_wr_en <= 1'b0;
        // Every word is stored once this edge has passed
        @(negedge clk);
        check_full(name, sent >= CMD_DEPTH, cmd_full);
        @(posedge clk);
    endtask

    // Queue the staged commands, start the sequencer and check every write and irq
    task automatic run_jobs(input string name);
        int n;
        int i;
        int waited;
        got_addr_q.delete();
        got_data_q.delete();
        got_irq_q.delete();
        got_cycle_q.delete();
        n = exp_addr_q.size();
        send_commands(name);
        op_en <= 1'b1;
        waited = 0;
        while (got_addr_q.size() < n && waited < 60 * n + 100) begin
            @(posedge clk);
            waited++;
        end
        if (got_addr_q.size() < n) begin
            $display("%s: only %0d of %0d result writes arrived", name, got_addr_q.size(), n);
            note_fail();
        end
        for (i = 0; i < n && got_addr_q.size() > 0; i++) begin
            check_addr(name, exp_addr_q.pop_front(), got_addr_q.pop_front());
            check_data(name, exp_data_q.pop_front(), got_data_q.pop_front());
            // irq may rise together with the last write only
            if (i < n - 1) check_irq(name, 1'b0, got_irq_q.pop_front());
        end
        @(negedge clk);
        waited = 0;
        while (irq !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        check_irq(name, 1'b1, irq);
        if (got_addr_q.size() > 0) begin
            $display("%s: %0d unexpected extra result writes", name, got_addr_q.size());
            note_fail();
        end
        @(posedge clk);
        op_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_irq(name, 1'b0, irq);
        if (im_q.size() != 0 || wb_q.size() != 0) begin
            $display("%s: operand words were left unread in the streams", name);
            note_fail();
        end
        im_q.delete();
        wb_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic begin_test();
        test_fail = 0;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (test_fail == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, test_fail);
    endtask

    task automatic test_conv3();
        begin_test();
        fill_random();
        stage_job(op_conv3, 32'h0000_0100);
        run_jobs("conv3");
        end_test("conv3");
    endtask

    task automatic test_conv3_conv1();
        begin_test();
        fill_random();
        stage_job(op_conv3_conv1, 32'h0000_0200);
        run_jobs("conv3_conv1");
        if (got_cycle_q.size() < 2 || got_cycle_q[1] - got_cycle_q[0] != 1) begin
            $display("conv3_conv1: the 1x1 write did not follow the 3x3 write directly");
            note_fail();
        end
        end_test("conv3_conv1");
    endtask

    task automatic test_pool();
        int i;
        begin_test();
        fill_random();
        stage_job(op_pool3, 32'h0000_0300);
        run_jobs("pool");
        for (i = 0; i < WIN; i++) cur_im[i] = DATA_W'(-1 - int'(next_rand() % 500));
        stage_job(op_pool3, 32'h0000_0310);
        run_jobs("pool");
        end_test("pool");
    endtask

    task automatic test_relu_sat();
        int i;
        begin_test();
        // Negative 3x3 sum clips to zero
        for (i = 0; i < WIN; i++) begin
            cur_im[i] = 16'sd10;
            cur_w[i]  = -16'sd10;
        end
        cur_b3 = 16'sd0;
        stage_job(op_conv3, 32'h0000_0400);
        // Large 3x3 sum saturates while the 1x1 sum goes negative
        for (i = 0; i < WIN; i++) begin
            cur_im[i] = 16'sd200;
            cur_w[i]  = 16'sd200;
        end
        cur_b3 = 16'sd100;
        cur_px = -16'sd20;
        cur_w1 = 16'sd30;
        cur_b1 = 16'sd5;
        stage_job(op_conv3_conv1, 32'h0000_0410);
        run_jobs("relu_sat");
        end_test("relu_sat");
    endtask

    task automatic hold_image();
        int base;
        int waited;
        int stretch;
        @(negedge clk);
        base = im_pops;
        waited = 0;
        stretch = 3 + int'(next_rand() % 8);
        while (im_pops < base + 2 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        im_hold = 1'b1;
        repeat (stretch) @(negedge clk);
        im_hold = 1'b0;
    endtask

    task automatic test_backpressure();
        begin_test();
        fill_random();
        stage_job(op_conv3_conv1, 32'h0000_0500);
        fork
            run_jobs("backpressure");
            hold_image();
        join
        end_test("backpressure");
    endtask

    task automatic test_queue_irq();
        begin_test();
        // Unknown commands ahead of the real ones fill the command FIFO
        stage_unknown(CMD_DEPTH / CMD_WORDS - 3);
        fill_random();
        stage_job(op_conv3, 32'h0000_0600);
        fill_random();
        stage_job(op_pool3, 32'h0000_0610);
        fill_random();
        stage_job(op_conv3_conv1, 32'h0000_0620);
        run_jobs("queue_irq");
        end_test("queue_irq");
    endtask

    // Watchdog
    initial begin
        repeat (TOTAL_LEN * 20) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_LEN * 20);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rng_state  = 32'd30;
        op_en      = 1'b0;
        cmd_wr_en  = 1'b0;
        cmd_wdata  = '0;
        data       = '0;
        im_empty   = 1'b1;
        weightbias = '0;
        iwb_empty  = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clk);
        test_conv3();
        test_conv3_conv1();
        test_pool();
        test_relu_sat();
        test_backpressure();
        test_queue_irq();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/cnn_pkg.sv
rtl/cmd_fifo.sv
rtl/csb.sv
rtl/conv_unit.sv
rtl/pool_max_3x3.sv
rtl/cnn_accel_top.sv
dv/tb_clk_gen.sv
dv/cnn_accel_tb.sv
